//--- src/s2mm_consts.svh
`ifndef S2MM_CONSTS_SVH
`define S2MM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// bus and image sizes
//////////////////////////////////////////////////////////////////////

`define S2MM_DATA_W      32  // one pixel word per beat.
`define S2MM_ADDR_W      32
`define S2MM_IMG_BITS    12  // width and height fields.

//////////////////////////////////////////////////////////////////////
// burst and line buffer
//////////////////////////////////////////////////////////////////////

`define S2MM_BURST_LEN   16  // max beats per burst.
`define S2MM_FIFO_DEPTH  32
`define S2MM_FIFO_CNT_W  6   // holds 0 to depth inclusive.

`endif

//--- src/s2mm_pkg.sv
`include "s2mm_consts.svh"

package s2mm_pkg;

	// frame controller phases.
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_SOF  = 3'd1,  // wait for the first pixel of a frame.
		ST_AW   = 3'd2,
		ST_W    = 3'd3,
		ST_B    = 3'd4,
		ST_DONE = 3'd5
	} s2mm_state_t;

	// one line buffer slot.
	typedef struct packed {
		logic [`S2MM_DATA_W-1:0] pixel;
		logic                    eol;  // tlast of the stream beat.
		logic                    sof;  // tuser of the stream beat.
	} fifo_entry_t;

endpackage

//--- src/s2mm_fifo_if.sv
`include "s2mm_consts.svh"

// read side of the line buffer.
interface s2mm_fifo_if;
	import s2mm_pkg::*;

	fifo_entry_t                 entry;  // head of the buffer.
	logic                        empty;
	logic [`S2MM_FIFO_CNT_W-1:0] count;
	logic                        pop;

	modport fifo (
		output entry,
		output empty,
		output count,
		input  pop
	);

	modport ctrl (
		input  entry,
		input  empty,
		input  count,
		output pop
	);

endinterface

//--- src/s2mm_line_fifo.sv
`include "s2mm_consts.svh"

module s2mm_line_fifo (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic [`S2MM_DATA_W-1:0] tdata,
	input  logic                    tvalid,
	input  logic                    tlast,
	input  logic                    tuser,
	input  logic                    armed,
	output logic                    tready,
	s2mm_fifo_if.fifo               fif
);
	import s2mm_pkg::*;

	localparam int CNT_W = `S2MM_FIFO_CNT_W;
	localparam int PTR_W = `S2MM_FIFO_CNT_W - 1;
	localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`S2MM_FIFO_DEPTH);

	fifo_entry_t      mem [0:`S2MM_FIFO_DEPTH-1];
	fifo_entry_t      wr_entry;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             started;
	logic             push;
	logic             pop;

	// every accepted beat is taken, only frame beats are kept.
	assign push = tvalid && tready && (tuser || started);
	assign pop  = fif.pop && !fif.empty;

	assign wr_entry.pixel = tdata;
	assign wr_entry.eol   = tlast;
	assign wr_entry.sof   = tuser;

	always_comb begin
		count_next = count;
		if (push && !pop) begin
			count_next = count + 1'b1;
		end else if (pop && !push) begin
			count_next = count - 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pointers, count and frame tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			started <= 1'b0;
			tready  <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count  <= count_next;
			tready <= (count_next != DEPTH);  // room left after this edge.
			if (push && tuser) begin
				started <= 1'b1;
			end else if (armed && fif.empty) begin
				started <= 1'b0;  // nothing useful left, drop until next sof.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	assign fif.entry = mem[rd_ptr];
	assign fif.empty = (count == '0);
	assign fif.count = count;

endmodule

//--- src/s2mm_beat_counter.sv
`include "s2mm_consts.svh"

module s2mm_beat_counter (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic [`S2MM_IMG_BITS-1:0] width,
	input  logic [`S2MM_IMG_BITS-1:0] height,
	input  logic                      load_frame,
	input  logic                      load_burst,
	input  logic                      beat,
	output logic [7:0]                burst_len,
	output logic                      burst_last,
	output logic                      line_end,
	output logic                      frame_end
);
	localparam int IMG_W = `S2MM_IMG_BITS;
	localparam logic [IMG_W-1:0] MAX_BURST = IMG_W'(`S2MM_BURST_LEN);

	logic [IMG_W-1:0] line_left;  // beats of the line from the current burst on.
	logic [IMG_W-1:0] rows_left;
	logic [IMG_W-1:0] next_left;
	logic [IMG_W-1:0] next_rows;
	logic [7:0]       burst_left;
	logic             pend;  // burst finished, not yet retired from the line.

	function automatic logic [7:0] clip_len(input logic [IMG_W-1:0] n);
		logic [IMG_W-1:0] m;
		m = (n > MAX_BURST) ? MAX_BURST : n;
		return 8'(m);
	endfunction

	assign burst_len  = clip_len(line_left);
	assign burst_last = (burst_left == 8'd1);
	assign line_end   = (line_left <= MAX_BURST);  // this burst closes the line.
	assign frame_end  = line_end && (rows_left == IMG_W'(1));

	// a burst that does not close the line is always a full one.
	always_comb begin
		next_left = line_left;
		next_rows = rows_left;
		if (pend) begin
			if (line_end) begin
				next_left = width;
				next_rows = rows_left - 1'b1;
			end else begin
				next_left = line_left - MAX_BURST;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			line_left  <= '0;
			rows_left  <= '0;
			burst_left <= '0;
			pend       <= 1'b0;
		end else if (load_frame) begin
			line_left  <= width;
			rows_left  <= height;
			burst_left <= '0;
			pend       <= 1'b0;
		end else if (load_burst) begin
			line_left  <= next_left;
			rows_left  <= next_rows;
			burst_left <= clip_len(next_left);
			pend       <= 1'b0;
		end else if (beat) begin
			burst_left <= burst_left - 1'b1;
			if (burst_last) begin
				pend <= 1'b1;
			end
		end
	end

endmodule

//--- src/s2mm_addr_gen.sv
`include "s2mm_consts.svh"

module s2mm_addr_gen (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic [`S2MM_ADDR_W-1:0] base,
	input  logic [`S2MM_ADDR_W-1:0] stride,
	input  logic                    load_frame,
	input  logic                    burst_done,
	input  logic [7:0]              burst_len,
	input  logic                    line_done,
	output logic [`S2MM_ADDR_W-1:0] awaddr
);
	localparam int ADDR_W = `S2MM_ADDR_W;

	logic [ADDR_W-1:0] line_base;
	logic [ADDR_W-1:0] burst_addr;
	logic [ADDR_W-1:0] burst_bytes;
	logic [ADDR_W-1:0] next_line;

	assign burst_bytes = ADDR_W'({burst_len, 2'b00});  // 4 bytes per beat.
	assign next_line   = line_base + stride;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			line_base  <= '0;
			burst_addr <= '0;
		end else if (load_frame) begin
			line_base  <= base;
			burst_addr <= base;
		end else if (burst_done) begin
			if (line_done) begin
				line_base  <= next_line;
				burst_addr <= next_line;
			end else begin
				burst_addr <= burst_addr + burst_bytes;
			end
		end
	end

	assign awaddr = burst_addr;

endmodule

//--- src/s2mm_frame_ctrl.sv
`include "s2mm_consts.svh"

module s2mm_frame_ctrl (
	input  logic       clk,
	input  logic       resetn,
	input  logic       start,
	input  logic       awready,
	input  logic       wready,
	input  logic       bvalid,
	input  logic [7:0] burst_len,
	input  logic       burst_last,
	input  logic       line_end,
	input  logic       frame_end,
	output logic       awvalid,
	output logic       wvalid,
	output logic       wlast,
	output logic       bready,
	output logic       armed,
	output logic       load_frame,
	output logic       load_burst,
	output logic       beat,
	output logic       burst_done,
	output logic       line_done,
	output logic       frame_done,
	s2mm_fifo_if.ctrl  fif
);
	import s2mm_pkg::*;

	s2mm_state_t state;
	s2mm_state_t state_next;
	logic        w_fire;
	logic        enough;  // first burst of the frame is buffered.

	assign w_fire = wvalid && wready;
	assign enough = (8'(fif.count) >= burst_len);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// phase sequencing
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		load_frame = 1'b0;
		load_burst = 1'b0;
		beat       = 1'b0;
		burst_done = 1'b0;
		line_done  = 1'b0;
		fif.pop    = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start) begin
					state_next = ST_SOF;
					load_frame = 1'b1;
				end
			end
			ST_SOF: begin
				if (!fif.empty) begin
					if (!fif.entry.sof) begin
						fif.pop = 1'b1;  // stale beat ahead of the frame.
					end else if (enough) begin
						state_next = ST_AW;
						load_burst = 1'b1;
					end
				end
			end
			ST_AW: begin
				if (awready) begin
					state_next = ST_W;
				end
			end
			ST_W: begin
				beat    = w_fire;
				fif.pop = w_fire;
				if (w_fire && burst_last) begin
					state_next = ST_B;
				end
			end
			ST_B: begin
				if (bvalid) begin
					burst_done = 1'b1;
					line_done  = line_end;
					if (frame_end) begin
						state_next = ST_DONE;
					end else begin
						state_next = ST_AW;
						load_burst = 1'b1;
					end
				end
			end
			ST_DONE: begin
				state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	assign awvalid    = (state == ST_AW);
	assign wvalid     = (state == ST_W) && !fif.empty;
	assign wlast      = (state == ST_W) && burst_last;
	assign bready     = (state == ST_B);
	assign armed      = (state == ST_SOF);
	assign frame_done = (state == ST_DONE);

endmodule

//--- src/s2mm_writer.sv
`include "s2mm_consts.svh"

module s2mm_writer (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      start,
	input  logic [`S2MM_ADDR_W-1:0]   base,
	input  logic [`S2MM_ADDR_W-1:0]   stride,
	input  logic [`S2MM_IMG_BITS-1:0] width,
	input  logic [`S2MM_IMG_BITS-1:0] height,
	output logic                      frame_done,
	// stream input.
	input  logic [`S2MM_DATA_W-1:0]   s_tdata,
	input  logic                      s_tvalid,
	output logic                      s_tready,
	input  logic                      s_tlast,
	input  logic                      s_tuser,
	// write address channel.
	output logic [`S2MM_ADDR_W-1:0]   m_awaddr,
	output logic [7:0]                m_awlen,
	output logic [2:0]                m_awsize,
	output logic [1:0]                m_awburst,
	output logic                      m_awvalid,
	input  logic                      m_awready,
	// write data channel.
	output logic [`S2MM_DATA_W-1:0]   m_wdata,
	output logic [`S2MM_DATA_W/8-1:0] m_wstrb,
	output logic                      m_wlast,
	output logic                      m_wvalid,
	input  logic                      m_wready,
	// write response channel.
	input  logic                      m_bvalid,
	output logic                      m_bready,
	input  logic [1:0]                m_bresp
);
	s2mm_fifo_if fif_bus ();

	logic       armed;
	logic       load_frame;
	logic       load_burst;
	logic       beat;
	logic       burst_done;
	logic       line_done;
	logic [7:0] burst_len;
	logic       burst_last;
	logic       line_end;
	logic       frame_end;

	s2mm_line_fifo u_fifo (
		.clk    (clk),
		.resetn (resetn),
		.tdata  (s_tdata),
		.tvalid (s_tvalid),
		.tlast  (s_tlast),
		.tuser  (s_tuser),
		.armed  (armed),
		.tready (s_tready),
		.fif    (fif_bus.fifo)
	);

	s2mm_beat_counter u_counter (
		.clk        (clk),
		.resetn     (resetn),
		.width      (width),
		.height     (height),
		.load_frame (load_frame),
		.load_burst (load_burst),
		.beat       (beat),
		.burst_len  (burst_len),
		.burst_last (burst_last),
		.line_end   (line_end),
		.frame_end  (frame_end)
	);

	s2mm_addr_gen u_addr (
		.clk        (clk),
		.resetn     (resetn),
		.base       (base),
		.stride     (stride),
		.load_frame (load_frame),
		.burst_done (burst_done),
		.burst_len  (burst_len),
		.line_done  (line_done),
		.awaddr     (m_awaddr)
	);

	s2mm_frame_ctrl u_ctrl (
		.clk        (clk),
		.resetn     (resetn),
		.start      (start),
		.awready    (m_awready),
		.wready     (m_wready),
		.bvalid     (m_bvalid),
		.burst_len  (burst_len),
		.burst_last (burst_last),
		.line_end   (line_end),
		.frame_end  (frame_end),
		.awvalid    (m_awvalid),
		.wvalid     (m_wvalid),
		.wlast      (m_wlast),
		.bready     (m_bready),
		.armed      (armed),
		.load_frame (load_frame),
		.load_burst (load_burst),
		.beat       (beat),
		.burst_done (burst_done),
		.line_done  (line_done),
		.frame_done (frame_done),
		.fif        (fif_bus.ctrl)
	);

	assign m_awlen   = burst_len - 8'd1;
	assign m_awsize  = 3'b010;  // 4 bytes per beat.
	assign m_awburst = 2'b01;  // incr.
	assign m_wdata   = fif_bus.entry.pixel;
	assign m_wstrb   = '1;

endmodule

//--- verif/s2mm_assertions.sv
`include "s2mm_consts.svh"

module s2mm_assertions (
	input logic                    clk,
	input logic                    resetn,
	input logic                    s_tready,
	input logic [`S2MM_ADDR_W-1:0] m_awaddr,
	input logic [7:0]              m_awlen,
	input logic                    m_awvalid,
	input logic                    m_awready,
	input logic [`S2MM_DATA_W-1:0] m_wdata,
	input logic                    m_wlast,
	input logic                    m_wvalid,
	input logic                    m_wready,
	input s2mm_pkg::s2mm_state_t   state
);
	timeunit 1ns;
	timeprecision 1ps;
	import s2mm_pkg::*;

	aw_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr) && $stable(m_awlen))
		else $error("write address dropped or changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wlast))
		else $error("write data dropped or changed before wready");

	// only a single beat burst starts its data phase with wlast.
	wlast_in_w: assert property (@(posedge clk) disable iff (!resetn)
		$rose(state == ST_W) |-> m_wlast == (m_awlen == 8'd0))
		else $error("wlast at the start of the data phase disagrees with awlen");

	// the line buffer opens one cycle late.
	tready_after_reset: assert property (@(posedge clk) $rose(resetn) |-> !s_tready)
		else $error("stream ready raised in the first cycle after reset");

endmodule

//--- verif/tb_s2mm_writer.sv
`include "s2mm_consts.svh"

module tb_s2mm_writer;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int SEED        = 40709;
	localparam int IMG_W       = `S2MM_IMG_BITS;
	localparam int NUM_FRAMES  = 3;
	localparam int NUM_JUNK    = 3;  // stale beats ahead of each frame.

	localparam logic [31:0] FRAME_BASE [NUM_FRAMES] = '{
		32'h1000_0000, 32'h2000_0000, 32'h3000_0400
	};
	localparam logic [31:0] FRAME_STRIDE [NUM_FRAMES] = '{32'h100, 32'h200, 32'h80};
	localparam int FRAME_W [NUM_FRAMES] = '{21, 32, 5};
	localparam int FRAME_H [NUM_FRAMES] = '{4, 3, 2};

	logic                      clk = 1'b0;
	logic                      resetn;
	logic                      start;
	logic [`S2MM_ADDR_W-1:0]   base;
	logic [`S2MM_ADDR_W-1:0]   stride;
	logic [IMG_W-1:0]          width;
	logic [IMG_W-1:0]          height;
	logic                      frame_done;
	logic [`S2MM_DATA_W-1:0]   s_tdata;
	logic                      s_tvalid;
	logic                      s_tready;
	logic                      s_tlast;
	logic                      s_tuser;
	logic [`S2MM_ADDR_W-1:0]   m_awaddr;
	logic [7:0]                m_awlen;
	logic [2:0]                m_awsize;
	logic [1:0]                m_awburst;
	logic                      m_awvalid;
	logic                      m_awready;
	logic [`S2MM_DATA_W-1:0]   m_wdata;
	logic [`S2MM_DATA_W/8-1:0] m_wstrb;
	logic                      m_wlast;
	logic                      m_wvalid;
	logic                      m_wready;
	logic                      m_bvalid;
	logic                      m_bready;
	logic [1:0]                m_bresp;

	logic [31:0]               exp_addr [$];
	logic [7:0]                exp_len [$];
	logic [31:0]               exp_data [$];
	logic                      exp_last [$];
	logic [`S2MM_DATA_W+1:0]   src_beats [$];  // {tuser, tlast, tdata}.
	int                        done_count;
	int                        b_pending;
	int                        cycle_count;
	int                        timeout_limit;

	s2mm_writer DUT (
		.clk        (clk),
		.resetn     (resetn),
		.start      (start),
		.base       (base),
		.stride     (stride),
		.width      (width),
		.height     (height),
		.frame_done (frame_done),
		.s_tdata    (s_tdata),
		.s_tvalid   (s_tvalid),
		.s_tready   (s_tready),
		.s_tlast    (s_tlast),
		.s_tuser    (s_tuser),
		.m_awaddr   (m_awaddr),
		.m_awlen    (m_awlen),
		.m_awsize   (m_awsize),
		.m_awburst  (m_awburst),
		.m_awvalid  (m_awvalid),
		.m_awready  (m_awready),
		.m_wdata    (m_wdata),
		.m_wstrb    (m_wstrb),
		.m_wlast    (m_wlast),
		.m_wvalid   (m_wvalid),
		.m_wready   (m_wready),
		.m_bvalid   (m_bvalid),
		.m_bready   (m_bready),
		.m_bresp    (m_bresp)
	);

	bind s2mm_writer s2mm_assertions u_assert (
		.clk       (clk),
		.resetn    (resetn),
		.s_tready  (s_tready),
		.m_awaddr  (m_awaddr),
		.m_awlen   (m_awlen),
		.m_awvalid (m_awvalid),
		.m_awready (m_awready),
		.m_wdata   (m_wdata),
		.m_wlast   (m_wlast),
		.m_wvalid  (m_wvalid),
		.m_wready  (m_wready),
		.state     (u_ctrl.state)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model and stream source
	//////////////////////////////////////////////////////////////////////

	function automatic int total_beats();
		int sum;
		sum = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			sum += FRAME_W[f] * FRAME_H[f];
		end
		return sum;
	endfunction

	task automatic build_model(input int f);
		int          col;
		int          len;
		logic [31:0] row_base;
		for (int r = 0; r < FRAME_H[f]; r++) begin
			row_base = FRAME_BASE[f] + FRAME_STRIDE[f] * 32'(r);
			col = 0;
			while (col < FRAME_W[f]) begin
				len = (FRAME_W[f] - col > `S2MM_BURST_LEN) ? `S2MM_BURST_LEN : FRAME_W[f] - col;
				exp_addr.push_back(row_base + 32'(col * 4));
				exp_len.push_back(8'(len));
				for (int i = 0; i < len; i++) begin
					exp_data.push_back(32'(r * 65536 + col + i));
					exp_last.push_back(i == len - 1);
				end
				col += len;
			end
		end
	endtask

	task automatic queue_stream(input int f);
		for (int j = 0; j < NUM_JUNK; j++) begin
			src_beats.push_back({1'b0, j == NUM_JUNK - 1, 32'hbad0_0000 + 32'(j)});
		end
		for (int r = 0; r < FRAME_H[f]; r++) begin
			for (int c = 0; c < FRAME_W[f]; c++) begin
				src_beats.push_back({r == 0 && c == 0, c == FRAME_W[f] - 1, 32'(r * 65536 + c)});
			end
		end
	endtask

	task automatic check_aw();
		if (exp_addr.size() == 0) begin
			abort_run("write burst issued after the last burst of the frame");
		end else begin
			check_val("m_awaddr", m_awaddr, exp_addr.pop_front());
			check_val("m_awlen", 32'(m_awlen), 32'(exp_len.pop_front() - 8'd1));
			check_val("m_awsize", 32'(m_awsize), 32'd2);
			check_val("m_awburst", 32'(m_awburst), 32'd1);
		end
	endtask

	task automatic check_w();
		if (exp_data.size() == 0) begin
			abort_run("data beat written after the last beat of the frame");
		end else begin
			check_val("m_wdata", m_wdata, exp_data.pop_front());
			check_val("m_wlast", 32'(m_wlast), 32'(exp_last.pop_front()));
			check_val("m_wstrb", 32'(m_wstrb), 32'hf);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stream source and memory slave
	//////////////////////////////////////////////////////////////////////

	initial begin : bus_driver
		logic        aw_fire;
		logic        w_fire;
		logic        wlast_fire;
		logic        b_fire;
		logic        s_fire;
		int unsigned draw;
		void'($urandom(SEED));
		s_tdata   = '0;
		s_tvalid  = 1'b0;
		s_tlast   = 1'b0;
		s_tuser   = 1'b0;
		m_awready = 1'b0;
		m_wready  = 1'b0;
		m_bvalid  = 1'b0;
		m_bresp   = 2'b00;
		b_pending = 0;
		done_count = 0;
		forever begin
			@(negedge clk);  // handshakes here complete at the next edge.
			aw_fire    = m_awvalid && m_awready;
			w_fire     = m_wvalid && m_wready;
			wlast_fire = w_fire && m_wlast;
			b_fire     = m_bvalid && m_bready;
			s_fire     = s_tvalid && s_tready;
			if (aw_fire) begin
				check_aw();
			end
			if (w_fire) begin
				check_w();
			end
			if (frame_done) begin
				done_count++;
			end
			next_cycle();
			if (s_fire) begin
				void'(src_beats.pop_front());
			end
			if (wlast_fire) begin
				b_pending++;
			end
			if (b_fire) begin
				m_bvalid = 1'b0;
				b_pending--;
			end
			if (!m_bvalid && b_pending > 0) begin
				m_bvalid = ($urandom % 2) != 0;
			end
			m_awready = ($urandom % 4) != 0;
			m_wready  = ($urandom % 4) != 0;
			draw = $urandom % 4;
			if (src_beats.size() > 0 && draw != 0) begin
				s_tvalid = 1'b1;
				{s_tuser, s_tlast, s_tdata} = src_beats[0];
			end else begin
				s_tvalid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycle_count   = 0;
		timeout_limit = 8 * total_beats() + 200;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > timeout_limit) begin
				abort_run($sformatf("timeout: frame_done never arrived within %0d cycles",
					timeout_limit));
			end
		end
	end

	task automatic run_frame(input int f);
		base   = FRAME_BASE[f];
		stride = FRAME_STRIDE[f];
		width  = IMG_W'(FRAME_W[f]);
		height = IMG_W'(FRAME_H[f]);
		build_model(f);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		@(negedge clk);
		queue_stream(f);
		while (done_count < f + 1) begin
			next_cycle();
		end
		repeat (3) next_cycle();
		check_val("frame_done count", 32'(done_count), 32'(f + 1));
		check_val("bursts left", 32'(exp_addr.size()), 32'd0);
		check_val("beats left", 32'(exp_data.size()), 32'd0);
	endtask

	initial begin : main_seq
		resetn = 1'b0;
		start  = 1'b0;
		base   = '0;
		stride = '0;
		width  = '0;
		height = '0;
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		resetn = 1'b1;
		@(negedge clk);
		check_val("m_awvalid", 32'(m_awvalid), 32'd0);
		check_val("m_wvalid", 32'(m_wvalid), 32'd0);
		check_val("m_bready", 32'(m_bready), 32'd0);
		check_val("s_tready", 32'(s_tready), 32'd0);
		check_val("frame_done", 32'(frame_done), 32'd0);
		next_cycle();
		for (int f = 0; f < NUM_FRAMES; f++) begin
			run_frame(f);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- src.f
+incdir+src
src/s2mm_pkg.sv
src/s2mm_fifo_if.sv
src/s2mm_line_fifo.sv
src/s2mm_beat_counter.sv
src/s2mm_addr_gen.sv
src/s2mm_frame_ctrl.sv
src/s2mm_writer.sv
verif/s2mm_assertions.sv
verif/tb_s2mm_writer.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_s2mm_writer -f src.f -o sim \
	&& ./obj_dir/sim 2>&1 | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }

grep -q "Result: PASSED" sim.log && exit 0 || { echo "pass line not found in sim.log"; exit 1; }
